// File: Makefile
# Verilator build and run for the merge subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_merge_subsystem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/merge_config_loader.sv
// filters memory-program responses in the configuration window and builds merge configurations
module merge_config_loader
    import merge_pkg::*;
(
    input  logic   ap_clk,
    input  logic   reset,
    input  logic   mem_valid,
    input  cmd_t   mem_cmd,
    input  addr_t  mem_offset,
    input  shift_t mem_shift,
    input  data_t  mem_data,
    input  logic   cfg_full,
    output logic   cfg_push,
    output cfg_t   cfg_word,
    output logic   cfg_overflow
);

    // ------------------------------------------------------------------
    // input register
    // ------------------------------------------------------------------
    logic   mem_valid_reg;
    cmd_t   mem_cmd_reg;
    addr_t  mem_offset_reg;
    shift_t mem_shift_reg;
    data_t  mem_data_reg;

    addr_t word_idx;
    logic  in_window;
    logic  accept;
    logic  is_base;
    logic  is_op;

    loader_state_t state;
    mask_t         mask_reg;
    cfg_t          cfg_assembled;
    logic          cfg_done;

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            mem_valid_reg <= 1'b0;
        end else begin
            mem_valid_reg <= mem_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_cmd_reg    <= mem_cmd;
        mem_offset_reg <= mem_offset;
        mem_shift_reg  <= mem_shift;
        mem_data_reg   <= mem_data;
    end

    // ------------------------------------------------------------------
    // window filter
    // ------------------------------------------------------------------
    assign word_idx  = mem_offset_reg >> mem_shift_reg;
    assign in_window = (word_idx >= addr_t'(CFG_SEQ_BASE)) &&
                       (word_idx < addr_t'(CFG_SEQ_BASE + CFG_SEQ_LEN));
    assign accept    = mem_valid_reg && (mem_cmd_reg == CMD_MEM_PROGRAM) && in_window;
    assign is_base   = accept && (word_idx == addr_t'(CFG_SEQ_BASE));
    assign is_op     = accept && (word_idx == addr_t'(CFG_SEQ_BASE + 1));

    // ------------------------------------------------------------------
    // assembly FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            state    <= LOAD_IDLE;
            cfg_done <= 1'b0;
        end else begin
            cfg_done <= 1'b0;
            case (state)
                LOAD_IDLE: begin
                    if (is_base) begin
                        state <= LOAD_OP;
                    end
                end
                LOAD_OP: begin
                    // a repeated base word simply stays here with a fresh mask
                    if (is_op) begin
                        state    <= LOAD_IDLE;
                        cfg_done <= 1'b1;
                    end
                end
                default: state <= LOAD_IDLE;
            endcase
        end
    end

    // a base word reloads the mask in either state
    always_ff @(posedge ap_clk) begin
        if (is_base) begin
            mask_reg <= mem_data_reg[NUM_FIELDS-1:0];
        end
        if (is_op && state == LOAD_OP) begin
            cfg_assembled <= {mem_data_reg[OP_W-1:0], mask_reg};
        end
    end

    // ------------------------------------------------------------------
    // push stage
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            cfg_push     <= 1'b0;
            cfg_overflow <= 1'b0;
        end else begin
            cfg_push     <= cfg_done & ~cfg_full;
            cfg_overflow <= cfg_done & cfg_full;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cfg_done) begin
            cfg_word <= cfg_assembled;
        end
    end

    a_push_xor_ovf : assert property (@(posedge ap_clk) disable iff (reset)
        !(cfg_push && cfg_overflow));

endmodule : merge_config_loader

// File: design/merge_data_engine.sv
// holds the active merge configuration and reduces each data packet to one field
module merge_data_engine
    import merge_pkg::*;
(
    input  logic   ap_clk,
    input  logic   reset,
    input  logic   cfg_next,
    input  cfg_t   fifo_head,
    input  logic   fifo_empty,
    input  logic   data_valid,
    input  data_t  data_in,
    output logic   fifo_pop,
    output logic   cfg_active,
    output logic   result_valid,
    output field_t result
);

    cfg_t active_cfg;

    // ------------------------------------------------------------------
    // reduction over the enabled fields
    // ------------------------------------------------------------------
    function automatic field_t merge_reduce(input data_t data, input cfg_t cfg);
        mask_t     mask;
        merge_op_t op;
        field_t    acc;
        field_t    fld;
        int        k;
        mask = cfg[NUM_FIELDS-1:0];
        op   = merge_op_t'(cfg[OP_W+NUM_FIELDS-1:NUM_FIELDS]);
        // start from the identity so a zero mask returns it
        acc  = (op == MERGE_MIN) ? '1 : '0;
        for (k = 0; k < NUM_FIELDS; k++) begin
            fld = data[k*FIELD_W +: FIELD_W];
            if (mask[k]) begin
                case (op)
                    MERGE_SUM: acc = acc + fld;
                    MERGE_MAX: acc = (fld > acc) ? fld : acc;
                    MERGE_MIN: acc = (fld < acc) ? fld : acc;
                    MERGE_OR:  acc = acc | fld;
                    default:   acc = acc;
                endcase
            end
        end
        return acc;
    endfunction

    // ------------------------------------------------------------------
    // configuration pop
    // ------------------------------------------------------------------
    assign fifo_pop = cfg_next & ~fifo_empty;

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            cfg_active <= 1'b0;
        end else if (fifo_pop) begin
            cfg_active <= 1'b1;
        end
    end

    // new head applies from the next data cycle on
    always_ff @(posedge ap_clk) begin
        if (fifo_pop) begin
            active_cfg <= fifo_head;
        end
    end

    // ------------------------------------------------------------------
    // result register
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= data_valid & cfg_active;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (data_valid && cfg_active) begin
            result <= merge_reduce(data_in, active_cfg);
        end
    end

    a_result_needs_cfg : assert property (@(posedge ap_clk) disable iff (reset)
        result_valid |-> cfg_active);

endmodule : merge_data_engine

// File: design/merge_pkg.sv
// widths, types and encodings shared by the merge subsystem RTL and its testbench
package merge_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int NUM_FIELDS = 4;
    localparam int FIELD_W    = 8;
    localparam int ADDR_W     = 16;
    localparam int SHIFT_W    = 3;
    localparam int OP_W       = 2;

    // configuration window, in word indices
    localparam int CFG_SEQ_BASE = 4;
    localparam int CFG_SEQ_LEN  = 2;

    // configuration queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef logic [FIELD_W-1:0]            field_t;
    typedef logic [NUM_FIELDS*FIELD_W-1:0] data_t;
    typedef logic [ADDR_W-1:0]             addr_t;
    typedef logic [SHIFT_W-1:0]            shift_t;
    typedef logic [NUM_FIELDS-1:0]         mask_t;

    // op in the upper bits, mask in the lower bits
    typedef logic [OP_W+NUM_FIELDS-1:0] cfg_t;

    typedef enum logic [1:0] {
        CMD_INVALID,
        CMD_MEM_READ,
        CMD_MEM_PROGRAM,
        CMD_MEM_WRITE
    } cmd_t;

    typedef enum logic [OP_W-1:0] {
        MERGE_SUM,
        MERGE_MAX,
        MERGE_MIN,
        MERGE_OR
    } merge_op_t;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_OP
    } loader_state_t;

endpackage : merge_pkg

// File: design/merge_subsystem_top.sv
// merge subsystem top level joining the config loader, config FIFO and merge engine
module merge_subsystem_top
    import merge_pkg::*;
(
    input  logic   ap_clk,
    input  logic   reset,
    input  logic   mem_valid,
    input  cmd_t   mem_cmd,
    input  addr_t  mem_offset,
    input  shift_t mem_shift,
    input  data_t  mem_data,
    input  logic   cfg_next,
    input  logic   data_valid,
    input  data_t  data_in,
    output logic   result_valid,
    output field_t result,
    output logic   cfg_active,
    output logic   cfg_pending,
    output logic   cfg_overflow
);

    // ------------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------------
    logic cfg_push;
    cfg_t cfg_word;
    logic cfg_full;
    logic fifo_pop;
    cfg_t fifo_head;
    logic fifo_empty;

    assign cfg_pending = ~fifo_empty;

    merge_config_loader i_loader (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_cmd      (mem_cmd),
        .mem_offset   (mem_offset),
        .mem_shift    (mem_shift),
        .mem_data     (mem_data),
        .cfg_full     (cfg_full),
        .cfg_push     (cfg_push),
        .cfg_word     (cfg_word),
        .cfg_overflow (cfg_overflow)
    );

    sync_fifo i_cfg_fifo (
        .ap_clk (ap_clk),
        .reset  (reset),
        .push   (cfg_push),
        .din    (cfg_word),
        .pop    (fifo_pop),
        .dout   (fifo_head),
        .full   (cfg_full),
        .empty  (fifo_empty)
    );

    merge_data_engine i_engine (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .cfg_next     (cfg_next),
        .fifo_head    (fifo_head),
        .fifo_empty   (fifo_empty),
        .data_valid   (data_valid),
        .data_in      (data_in),
        .fifo_pop     (fifo_pop),
        .cfg_active   (cfg_active),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule : merge_subsystem_top

// File: design/sync_fifo.sv
// first-word-fall-through queue for completed merge configurations, head visible on dout
module sync_fifo
    import merge_pkg::*;
(
    input  logic ap_clk,
    input  logic reset,
    input  logic push,
    input  cfg_t din,
    input  logic pop,
    output cfg_t dout,
    output logic full,
    output logic empty
);

    // ------------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------------
    cfg_t                  mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // requests that cannot be honoured are ignored
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // head of queue, valid whenever not empty
    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // depth is a power of two so pointers wrap on their own
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // the loader must hold back pushes while full
    a_no_push_full : assert property (@(posedge ap_clk) disable iff (reset)
        !(push && full));

    // the engine gates its pop with the empty flag
    a_no_pop_empty : assert property (@(posedge ap_clk) disable iff (reset)
        !(pop && empty));

endmodule : sync_fifo

// File: src.f
design/merge_pkg.sv
design/sync_fifo.sv
design/merge_config_loader.sv
design/merge_data_engine.sv
design/merge_subsystem_top.sv
verif/tb_merge_subsystem.sv

// File: verif/tb_merge_subsystem.sv
// self-checking testbench for the merge subsystem, simulation top with LFSR stimulus and a model
module tb_merge_subsystem
    import merge_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // cycle budget per phase, the timeout adds a margin on top
    localparam int RESET_CYC    = 3;
    localparam int FILTER_CYC   = 50;
    localparam int ASSEMBLY_CYC = 20;
    localparam int OVERFLOW_CYC = 45;
    localparam int MERGE_CYC    = 80;
    localparam int SWITCH_CYC   = 60;
    localparam int TIMEOUT_CYC  = RESET_CYC + FILTER_CYC + ASSEMBLY_CYC + OVERFLOW_CYC +
                                  MERGE_CYC + SWITCH_CYC + 100;

    logic   ap_clk;
    logic   reset;
    logic   mem_valid;
    cmd_t   mem_cmd;
    addr_t  mem_offset;
    shift_t mem_shift;
    data_t  mem_data;
    logic   cfg_next;
    logic   data_valid;
    data_t  data_in;
    logic   result_valid;
    field_t result;
    logic   cfg_active;
    logic   cfg_pending;
    logic   cfg_overflow;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          ovf_count;

    // reference model
    loader_state_t m_state;
    mask_t         m_mask;
    logic          cmpl;
    cfg_t          cmpl_cfg;
    logic          cmpl_d1;
    cfg_t          cmpl_d1_cfg;
    logic          push_req;
    cfg_t          push_req_cfg;
    cfg_t          m_queue[$];
    logic          m_active;
    cfg_t          m_active_cfg;
    logic          exp_ovf;
    logic          exp_rv;
    field_t        exp_res;

    merge_subsystem_top i_dut (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_cmd      (mem_cmd),
        .mem_offset   (mem_offset),
        .mem_shift    (mem_shift),
        .mem_data     (mem_data),
        .cfg_next     (cfg_next),
        .data_valid   (data_valid),
        .data_in      (data_in),
        .result_valid (result_valid),
        .result       (result),
        .cfg_active   (cfg_active),
        .cfg_pending  (cfg_pending),
        .cfg_overflow (cfg_overflow)
    );

    always #50 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------
    // random numbers
    // ------------------------------------------------------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // ------------------------------------------------------------------
    // model
    // ------------------------------------------------------------------
    function automatic field_t expected_merge(input data_t data, input cfg_t cfg);
        merge_op_t op;
        field_t    f;
        field_t    best;
        int        sum;
        int        k;
        op   = merge_op_t'(cfg[NUM_FIELDS +: OP_W]);
        sum  = 0;
        best = (op == MERGE_MIN) ? 8'hff : 8'h00;
        for (k = 0; k < NUM_FIELDS; k++) begin
            f = data[k*FIELD_W +: FIELD_W];
            if (cfg[k]) begin
                case (op)
                    MERGE_SUM: sum = sum + int'(f);
                    MERGE_MAX: if (f > best) best = f;
                    MERGE_MIN: if (f < best) best = f;
                    default:   best = best | f;
                endcase
            end
        end
        if (op == MERGE_SUM) begin
            return field_t'(sum % 256);
        end
        return best;
    endfunction

    // one clock edge of the model, inputs as sampled at that edge
    task automatic model_edge();
        logic  full_now;
        logic  empty_now;
        addr_t idx;
        full_now  = (m_queue.size() == FIFO_DEPTH);
        empty_now = (m_queue.size() == 0);
        // data uses the configuration held before this edge
        exp_rv = data_valid && m_active;
        if (exp_rv) begin
            exp_res = expected_merge(data_in, m_active_cfg);
        end
        exp_ovf = cmpl_d1 && full_now;
        if (cfg_next && !empty_now) begin
            m_active_cfg = m_queue.pop_front();
            m_active     = 1'b1;
        end
        if (push_req) begin
            m_queue.push_back(push_req_cfg);
        end
        push_req     = cmpl_d1 && !full_now;
        push_req_cfg = cmpl_d1_cfg;
        cmpl_d1      = cmpl;
        cmpl_d1_cfg  = cmpl_cfg;
        cmpl         = 1'b0;
        idx = mem_offset >> mem_shift;
        if (mem_valid && mem_cmd == CMD_MEM_PROGRAM && idx >= addr_t'(CFG_SEQ_BASE) &&
            idx < addr_t'(CFG_SEQ_BASE + CFG_SEQ_LEN)) begin
            if (idx == addr_t'(CFG_SEQ_BASE)) begin
                m_mask  = mem_data[NUM_FIELDS-1:0];
                m_state = LOAD_OP;
            end else if (m_state == LOAD_OP) begin
                cmpl_cfg = {mem_data[OP_W-1:0], m_mask};
                cmpl     = 1'b1;
                m_state  = LOAD_IDLE;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_result(input field_t got, input field_t exp);
        if (got !== exp) begin
            $display("ERR @%0t: result got %02h expected %02h", $time, got, exp);
            $display("Test failures found");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_cfg_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %0b expected %0b", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR @%0t: cfg_overflow got %0b expected %0b", $time, got, exp);
            $display("Test failures found");
            $fatal(1, "overflow mismatch");
        end
    endtask

    task automatic compare_outputs();
        check_cfg_flag("cfg_pending", cfg_pending, m_queue.size() != 0);
        check_cfg_flag("cfg_active", cfg_active, m_active);
        check_cfg_flag("result_valid", result_valid, exp_rv);
        check_overflow(cfg_overflow, exp_ovf);
        if (exp_rv) begin
            check_result(result, exp_res);
        end
        if (cfg_overflow) begin
            ovf_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------------
    // inputs change only here, on the falling edge
    task automatic tick();
        @(posedge ap_clk);
        model_edge();
        @(negedge ap_clk);
        compare_outputs();
        mem_valid  = 1'b0;
        cfg_next   = 1'b0;
        data_valid = 1'b0;
    endtask

    task automatic send_response(input cmd_t cmd, input addr_t offset, input shift_t sh,
                                 input data_t data);
        mem_valid  = 1'b1;
        mem_cmd    = cmd;
        mem_offset = offset;
        mem_shift  = sh;
        mem_data   = data;
        tick();
    endtask

    // random shift, low offset bits below the shift are don't care
    task automatic send_word(input cmd_t cmd, input addr_t idx, input data_t data);
        shift_t sh;
        addr_t  low;
        sh  = shift_t'(rand_bits(3));
        low = addr_t'(rand_bits(7)) & ((addr_t'(1) << sh) - addr_t'(1));
        send_response(cmd, (idx << sh) | low, sh, data);
    endtask

    task automatic send_cfg(input mask_t mask, input merge_op_t op);
        send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE), {28'(rand_bits(28)), mask});
        send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE + 1), {30'(rand_bits(30)), op});
    endtask

    task automatic send_data(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            data_valid = 1'b1;
            data_in    = data_t'(rand_bits(32));
            tick();
        end
    endtask

    task automatic pop_cfg();
        cfg_next = 1'b1;
        tick();
    endtask

    task automatic wait_for_pending();
        while (!cfg_pending) begin
            tick();
        end
    endtask

    // ------------------------------------------------------------------
    // test phases
    // ------------------------------------------------------------------
    task automatic run_filter_phase();
        int    i;
        cmd_t  cmd;
        addr_t idx;
        for (i = 0; i < 40; i++) begin
            // data with no active configuration must stay silent
            data_valid = 1'b1;
            data_in    = data_t'(rand_bits(32));
            case (2'(rand_bits(2)))
                2'd0: begin
                    cmd = cmd_t'(2'(rand_bits(2)));
                    if (cmd == CMD_MEM_PROGRAM) begin
                        cmd = CMD_MEM_WRITE;
                    end
                    send_word(cmd, addr_t'(CFG_SEQ_BASE) + addr_t'(rand_bits(1)),
                              data_t'(rand_bits(32)));
                end
                2'd1: begin
                    idx = addr_t'(rand_bits(9));
                    if (idx >= addr_t'(CFG_SEQ_BASE) &&
                        idx < addr_t'(CFG_SEQ_BASE + CFG_SEQ_LEN)) begin
                        idx = idx + addr_t'(CFG_SEQ_LEN);
                    end
                    send_word(CMD_MEM_PROGRAM, idx, data_t'(rand_bits(32)));
                end
                2'd2: begin
                    // raw offset in the window, shifted out of it
                    send_response(CMD_MEM_PROGRAM,
                                  addr_t'(CFG_SEQ_BASE) + addr_t'(rand_bits(1)),
                                  shift_t'(rand_bits(2)) + shift_t'(1),
                                  data_t'(rand_bits(32)));
                end
                default: begin
                    // op word without a base word first
                    send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE + 1),
                              data_t'(rand_bits(32)));
                end
            endcase
        end
        repeat (4) tick();
        check_cfg_flag("cfg_pending", cfg_pending, 1'b0);
    endtask

    task automatic run_assembly_phase();
        send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE), data_t'(32'h0000_0031));
        tick();
        // newer base word replaces the mask
        send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE), data_t'(32'h0000_00fe));
        send_word(CMD_MEM_PROGRAM, addr_t'(CFG_SEQ_BASE + 1), {30'(rand_bits(30)), MERGE_SUM});
        wait_for_pending();
        pop_cfg();
        send_data(4);
    endtask

    task automatic run_overflow_phase();
        int i;
        for (i = 0; i < FIFO_DEPTH + 1; i++) begin
            send_cfg(mask_t'(rand_bits(4)), merge_op_t'(2'(rand_bits(2))));
        end
        repeat (4) tick();
        check_overflow(ovf_count == 1, 1'b1);
        for (i = 0; i < FIFO_DEPTH; i++) begin
            pop_cfg();
            send_data(3);
        end
        // pop on an empty queue keeps the last configuration
        pop_cfg();
        send_data(3);
    endtask

    task automatic run_merge_phase();
        int k;
        for (k = 0; k < 4; k++) begin
            send_cfg(mask_t'(rand_bits(4)), merge_op_t'(2'(k)));
            wait_for_pending();
            pop_cfg();
            send_data(8);
        end
    endtask

    task automatic run_switch_phase();
        int i;
        for (i = 0; i < 3; i++) begin
            send_cfg(mask_t'(rand_bits(4)), merge_op_t'(2'(rand_bits(2))));
        end
        for (i = 0; i < 30; i++) begin
            cfg_next   = (2'(rand_bits(2)) == 2'd0);
            data_valid = 1'(rand_bits(1));
            data_in    = data_t'(rand_bits(32));
            tick();
        end
        while (cfg_pending) begin
            pop_cfg();
        end
        pop_cfg();
        send_data(2);
    endtask

    initial begin
        ap_clk       = 1'b0;
        reset        = 1'b1;
        mem_valid    = 1'b0;
        mem_cmd      = CMD_INVALID;
        mem_offset   = '0;
        mem_shift    = '0;
        mem_data     = '0;
        cfg_next     = 1'b0;
        data_valid   = 1'b0;
        data_in      = '0;
        lfsr_state   = 32'hd168;
        cycle_count  = 0;
        ovf_count    = 0;
        m_state      = LOAD_IDLE;
        m_mask       = '0;
        cmpl         = 1'b0;
        cmpl_cfg     = '0;
        cmpl_d1      = 1'b0;
        cmpl_d1_cfg  = '0;
        push_req     = 1'b0;
        push_req_cfg = '0;
        m_active     = 1'b0;
        m_active_cfg = '0;
        exp_ovf      = 1'b0;
        exp_rv       = 1'b0;
        exp_res      = '0;
        repeat (RESET_CYC) @(posedge ap_clk);
        @(negedge ap_clk);
        reset = 1'b0;
        compare_outputs();
        run_filter_phase();
        run_assembly_phase();
        run_overflow_phase();
        run_merge_phase();
        run_switch_phase();
        $display("All tests passed!");
        $finish;
    end

endmodule : tb_merge_subsystem
